//--- verilog.f
hw/icache_pkg.sv
hw/icache_way.sv
hw/icache_hit_select.sv
hw/icache_refill.sv
hw/icache_top.sv
verification/tb_icache.sv

//--- run.sh
#!/bin/sh
# Build the icache testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_icache -o tb_icache \
    && ./obj_dir/tb_icache > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/tb_icache.sv
// Fetch tests against a word-serial memory model with random beat gaps; one fetch in flight at a time
module tb_icache;

    import icache_pkg::*;

    localparam logic [DATA_W-1:0] MEM_KEY = 32'h5A3C_96E1;
    localparam int                SEED    = 21124;
    localparam int BLOCK_BYTES  = BLOCK_WORDS * (DATA_W / 8);
    localparam int SET_STRIDE   = NUM_SETS * BLOCK_BYTES;  // Same set, next tag
    localparam int WAIT_LIMIT   = 64;
    localparam int STRESS_COUNT = 200;
    localparam logic [ADDR_W-1:0] STRESS_BASE = 32'h0001_0000;

    logic              Clk = 1'b0;
    logic              arst_n;
    logic              fetch_valid;
    logic [ADDR_W-1:0] fetch_addr;
    logic              mispredict;
    logic              invalidate;
    logic              fetch_ready;
    logic [DATA_W-1:0] fetch_instr;
    logic [DATA_W-1:0] mem_data;
    logic              mem_valid;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;

    int errors      = 0;
    int fetch_count = 0;
    int gap_q [$];  // Idle cycles before each beat

    always #50 Clk = ~Clk;

    icache_top dut (
        .Clk, .arst_n,
        .fetch_valid, .fetch_addr, .mispredict, .invalidate,
        .fetch_ready, .fetch_instr,
        .mem_data, .mem_valid, .mem_req, .mem_addr
    );

    // Backing store contents
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        return DATA_W'(a * 32'd3) ^ MEM_KEY;
    endfunction

    // Block k of the replacement test, all in set 0
    function automatic logic [ADDR_W-1:0] set0_block(input int k);
        return 32'h0000_4008 + ADDR_W'(k * SET_STRIDE);
    endfunction

    // Word-serial memory, aborts the burst once mem_req falls
    initial begin : mem_responder
        logic [ADDR_W-1:0] beat_addr;
        int gap;
        int beat;
        bit dropped;
        mem_valid = 1'b0;
        mem_data  = '0;
        forever begin
            @(negedge Clk);
            if (mem_req) begin
                beat_addr = mem_addr;
                dropped   = 1'b0;
                beat      = 0;
                while (beat < BLOCK_WORDS && !dropped) begin
                    gap = (gap_q.size() > 0) ? gap_q.pop_front() : 0;
                    while (gap > 0 && !dropped) begin
                        @(posedge Clk);
                        mem_valid <= 1'b0;
                        @(negedge Clk);
                        dropped = !mem_req;
                        gap--;
                    end
                    if (!dropped) begin
                        @(posedge Clk);
                        mem_valid <= 1'b1;
                        mem_data  <= mem_word(beat_addr);
                        @(negedge Clk);
                        dropped   = !mem_req;
                        beat_addr = beat_addr + 32'd4;
                        beat++;
                    end
                end
                @(posedge Clk);
                mem_valid <= 1'b0;
            end
        end
    end

    // Issue one fetch, wait for fetch_ready and check the word
    task automatic fetch_and_check(input logic [ADDR_W-1:0] addr, output int cycles,
                                   output bit missed);
        logic [ADDR_W-1:0] blk_addr;
        logic [DATA_W-1:0] expected;
        logic [DATA_W-1:0] instr;
        bit                done;
        blk_addr = addr & ~ADDR_W'(BLOCK_BYTES - 1);
        expected = mem_word(addr);
        instr    = '0;
        cycles   = 0;
        missed   = 1'b0;
        done     = 1'b0;
        fetch_count++;
        @(posedge Clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge Clk);
            if (mem_req && !missed) begin
                missed = 1'b1;
                assert (mem_addr == blk_addr) else begin
                    $display("Mismatch mem_addr: got %h expected %h", mem_addr, blk_addr);
                    errors++;
                end
            end
            if (fetch_ready) begin
                done  = 1'b1;
                instr = fetch_instr;
            end else begin
                cycles++;
            end
        end
        assert (done) else begin
            $display("Timeout waiting for fetch_ready on address %h", addr);
            errors++;
        end
        @(posedge Clk);
        fetch_valid <= 1'b0;
        if (done) begin
            assert (instr == expected) else begin
                $display("Mismatch fetch_instr at %h: got %h expected %h", addr, instr, expected);
                errors++;
            end
        end
    endtask

    task automatic expect_hit(input logic [ADDR_W-1:0] addr);
        int cycles;
        bit missed;
        fetch_and_check(addr, cycles, missed);
        assert (!missed) else begin
            $display("Refill requested for address %h, which should hit", addr);
            errors++;
        end
        assert (cycles == 1) else begin
            $display("Mismatch fetch_ready latency at %h: got %h expected %h", addr, cycles, 1);
            errors++;
        end
    endtask

    task automatic expect_miss(input logic [ADDR_W-1:0] addr);
        int cycles;
        bit missed;
        fetch_and_check(addr, cycles, missed);
        assert (missed) else begin
            $display("No refill request for address %h, which should miss", addr);
            errors++;
        end
    endtask

    task automatic cold_miss_then_hits();
        expect_miss(32'h0000_1024);
        expect_hit(32'h0000_1020);
        expect_hit(32'h0000_1028);
        expect_hit(32'h0000_102C);
    endtask

    // Four fills take ways 0..3, pointer wraps to way 0
    task automatic replace_in_full_set();
        for (int k = 0; k < NUM_WAYS; k++) begin
            expect_miss(set0_block(k));
        end
        for (int k = 0; k < NUM_WAYS; k++) begin
            expect_hit(set0_block(k));
        end
        expect_miss(set0_block(4));  // Evicts way 0
        expect_hit(set0_block(1));
        expect_miss(set0_block(0));
    endtask

    task automatic cancel_on_mispredict();
        logic [ADDR_W-1:0] addr;
        int                wait_cnt;
        bit                got_beat;
        bit                ready_seen;
        addr       = 32'h0000_2054;
        wait_cnt   = 0;
        got_beat   = 1'b0;
        ready_seen = 1'b0;
        @(posedge Clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        while (!got_beat && wait_cnt < WAIT_LIMIT) begin
            @(negedge Clk);
            wait_cnt++;
            got_beat = mem_req && mem_valid;
        end
        assert (got_beat) else begin
            $display("Timeout waiting for the first refill beat of %h", addr);
            errors++;
        end
        @(posedge Clk);  // First beat lands here
        mispredict  <= 1'b1;
        fetch_valid <= 1'b0;
        @(posedge Clk);
        mispredict <= 1'b0;
        @(negedge Clk);
        assert (!mem_req) else begin
            $display("mem_req still high one cycle after mispredict");
            errors++;
        end
        repeat (12) begin
            @(negedge Clk);
            if (fetch_ready) ready_seen = 1'b1;
        end
        assert (!ready_seen) else begin
            $display("fetch_ready pulsed for a cancelled fetch");
            errors++;
        end
        expect_miss(addr);  // Victim left invalid
    endtask

    task automatic invalidate_all();
        expect_hit(32'h0000_1028);
        @(posedge Clk);
        invalidate <= 1'b1;
        @(posedge Clk);
        invalidate <= 1'b0;
        expect_miss(32'h0000_1028);
    endtask

    task automatic random_stress();
        logic [ADDR_W-1:0] addr;
        int unsigned       blk;
        int unsigned       word;
        int                cycles;
        bit                missed;
        for (int i = 0; i < STRESS_COUNT; i++) begin
            blk  = $urandom_range(63, 0);
            word = $urandom_range(BLOCK_WORDS - 1, 0);
            addr = STRESS_BASE + ADDR_W'(blk * BLOCK_BYTES + word * 4);
            fetch_and_check(addr, cycles, missed);
            if (!missed) begin
                assert (cycles == 1) else begin
                    $display("Mismatch fetch_ready latency at %h: got %h expected %h",
                             addr, cycles, 1);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        mispredict  = 1'b0;
        invalidate  = 1'b0;
        void'($urandom(SEED));
        repeat (2048) gap_q.push_back($urandom_range(3, 0));
        repeat (10) @(posedge Clk);
        arst_n <= 1'b1;

        cold_miss_then_hits();
        replace_in_full_set();
        cancel_on_mispredict();
        invalidate_all();
        random_stress();

        $display("Fetches: %0d, errors: %0d", fetch_count, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- hw/icache_top.sv
// Blocking instruction cache; no writes or coherence, mispredict drops any refill in flight
module icache_top (
    input  logic                             Clk,
    input  logic                             arst_n,
    // Core fetch
    input  logic                             fetch_valid,
    input  logic [icache_pkg::ADDR_W-1:0]    fetch_addr,
    input  logic                             mispredict,
    input  logic                             invalidate,
    output logic                             fetch_ready,
    output logic [icache_pkg::DATA_W-1:0]    fetch_instr,
    // Word-serial memory
    input  logic [icache_pkg::DATA_W-1:0]    mem_data,
    input  logic                             mem_valid,
    output logic                             mem_req,
    output logic [icache_pkg::ADDR_W-1:0]    mem_addr
);

    import icache_pkg::*;

    logic [SET_W-1:0]    lookup_set;
    logic [TAG_W-1:0]    lookup_tag;
    logic [WORD_W-1:0]   lookup_word;
    logic [SET_W-1:0]    fill_set;
    logic [TAG_W-1:0]    fill_tag;
    logic [WORD_W-1:0]   fill_word;
    logic [DATA_W-1:0]   fill_data;
    logic                fill_start;
    logic                fill_beat;
    logic                fill_last;
    logic [NUM_WAYS-1:0] fill_way_sel;
    logic                inv_all;

    logic [NUM_WAYS-1:0]               way_hit;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] way_valid;
    logic [NUM_WAYS-1:0][DATA_W-1:0]   way_data;
    logic                              any_hit;
    logic [DATA_W-1:0]                 hit_data;
    logic [NUM_WAYS-1:0]               victim_sel;

    icache_refill u_refill (
        .Clk, .arst_n,
        .fetch_valid, .fetch_addr, .mispredict, .invalidate,
        .fetch_ready, .fetch_instr,
        .mem_data, .mem_valid, .mem_req, .mem_addr,
        .any_hit, .hit_data, .victim_sel,
        .lookup_set, .lookup_tag, .lookup_word,
        .fill_set, .fill_tag, .fill_word, .fill_data,
        .fill_start, .fill_beat, .fill_last, .fill_way_sel,
        .inv_all
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        icache_way u_way (
            .Clk, .arst_n,
            .lookup_set, .lookup_tag, .lookup_word,
            .fill_sel  (fill_way_sel[g]),
            .fill_set, .fill_tag, .fill_word, .fill_data,
            .fill_start, .fill_beat, .fill_last, .inv_all,
            .way_hit   (way_hit[g]),
            .way_valid (way_valid[g]),
            .way_data  (way_data[g])
        );
    end

    icache_hit_select u_hit_select (
        .Clk, .arst_n,
        .way_hit, .way_valid, .way_data,
        .lookup_set, .fill_set, .fill_last, .fill_way_sel,
        .any_hit, .hit_data, .victim_sel
    );

endmodule

//--- hw/icache_refill.sv
// One request in flight; core holds its fetch until fetch_ready, memory returns beats in order
module icache_refill (
    input  logic                             Clk,
    input  logic                             arst_n,
    // Core side
    input  logic                             fetch_valid,
    input  logic [icache_pkg::ADDR_W-1:0]    fetch_addr,
    input  logic                             mispredict,
    input  logic                             invalidate,
    output logic                             fetch_ready,
    output logic [icache_pkg::DATA_W-1:0]    fetch_instr,
    // Memory side
    input  logic [icache_pkg::DATA_W-1:0]    mem_data,
    input  logic                             mem_valid,
    output logic                             mem_req,
    output logic [icache_pkg::ADDR_W-1:0]    mem_addr,
    // From hit select
    input  logic                             any_hit,
    input  logic [icache_pkg::DATA_W-1:0]    hit_data,
    input  logic [icache_pkg::NUM_WAYS-1:0]  victim_sel,
    // To the ways
    output logic [icache_pkg::SET_W-1:0]     lookup_set,
    output logic [icache_pkg::TAG_W-1:0]     lookup_tag,
    output logic [icache_pkg::WORD_W-1:0]    lookup_word,
    output logic [icache_pkg::SET_W-1:0]     fill_set,
    output logic [icache_pkg::TAG_W-1:0]     fill_tag,
    output logic [icache_pkg::WORD_W-1:0]    fill_word,
    output logic [icache_pkg::DATA_W-1:0]    fill_data,
    output logic                             fill_start,
    output logic                             fill_beat,
    output logic                             fill_last,
    output logic [icache_pkg::NUM_WAYS-1:0]  fill_way_sel,
    output logic                             inv_all
);

    import icache_pkg::*;

    refill_state_e       state;
    logic [ADDR_W-1:0]   miss_addr;
    logic [NUM_WAYS-1:0] victim_q;
    logic [WORD_W-1:0]   beat_cnt;

    logic                lookup_en;
    logic                take_beat;
    logic                respond_now;
    logic [ADDR_W-1:0]   cur_addr;

    // Lookups are blocked while the previous answer is on the bus
    assign lookup_en = (state == ST_IDLE) && fetch_valid && !fetch_ready
                       && !mispredict && !invalidate;

    // Idle looks at the core, otherwise the miss being serviced
    assign cur_addr    = (state == ST_IDLE) ? fetch_addr : miss_addr;
    assign lookup_set  = cur_addr[SET_LSB +: SET_W];
    assign lookup_tag  = cur_addr[TAG_LSB +: TAG_W];
    assign lookup_word = cur_addr[WORD_LSB +: WORD_W];

    assign take_beat = ((state == ST_REQ) || (state == ST_FILL)) && mem_valid && !mispredict;

    assign fill_beat    = take_beat;
    assign fill_last    = take_beat && (beat_cnt == WORD_W'(BLOCK_WORDS - 1));
    assign fill_set     = miss_addr[SET_LSB +: SET_W];
    assign fill_tag     = miss_addr[TAG_LSB +: TAG_W];
    assign fill_word    = beat_cnt;
    assign fill_data    = mem_data;
    assign fill_way_sel = victim_q;

    assign inv_all = invalidate && (state == ST_IDLE);

    assign mem_addr = {miss_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}; // Block aligned

    // Hit in idle, or refilled word read back through the hit path
    assign respond_now = !mispredict
                         && ((lookup_en && any_hit) || (state == ST_RESPOND));

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ST_IDLE;
            miss_addr   <= '0;
            victim_q    <= '0;
            beat_cnt    <= '0;
            mem_req     <= 1'b0;
            fill_start  <= 1'b0;
            fetch_ready <= 1'b0;
        end else begin
            fetch_ready <= respond_now;
            fill_start  <= 1'b0;
            if (mispredict) begin
                // Drop the held request and leave the victim invalid
                state    <= ST_IDLE;
                mem_req  <= 1'b0;
                beat_cnt <= '0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (lookup_en && !any_hit) begin
                            miss_addr  <= fetch_addr;
                            victim_q   <= victim_sel;
                            beat_cnt   <= '0;
                            mem_req    <= 1'b1;
                            fill_start <= 1'b1; // Kills the victim line
                            state      <= ST_REQ;
                        end
                    end
                    ST_REQ: begin
                        if (take_beat) begin
                            beat_cnt <= beat_cnt + WORD_W'(1);
                            state    <= ST_FILL;
                        end
                    end
                    ST_FILL: begin
                        if (take_beat) begin
                            beat_cnt <= beat_cnt + WORD_W'(1);
                        end
                        if (fill_last) begin
                            mem_req <= 1'b0;
                            state   <= ST_RESPOND;
                        end
                    end
                    ST_RESPOND: begin
                        state <= ST_IDLE;
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (respond_now) begin
            fetch_instr <= hit_data;
        end
    end

    // Address must not move under the memory controller
    a_mem_addr_stable: assert property (
        @(posedge Clk) disable iff (!arst_n)
        mem_req && $past(mem_req) |-> $stable(mem_addr)
    ) else $error("mem_addr changed while mem_req held");

    // Beat counter and state must agree on the last beat
    a_last_in_fill: assert property (
        @(posedge Clk) disable iff (!arst_n)
        fill_last |-> (state == ST_FILL)
    ) else $error("fill_last outside ST_FILL");

endmodule

//--- hw/icache_hit_select.sv
// Victim is the lowest invalid way, else the set's round-robin pointer; pointer moves on fill_last
module icache_hit_select (
    input  logic                                                    Clk,
    input  logic                                                    arst_n,
    input  logic [icache_pkg::NUM_WAYS-1:0]                         way_hit,
    input  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::NUM_SETS-1:0] way_valid,
    input  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::DATA_W-1:0]   way_data,
    input  logic [icache_pkg::SET_W-1:0]                            lookup_set,
    input  logic [icache_pkg::SET_W-1:0]                            fill_set,
    input  logic                                                    fill_last,
    input  logic [icache_pkg::NUM_WAYS-1:0]                         fill_way_sel,
    output logic                                                    any_hit,
    output logic [icache_pkg::DATA_W-1:0]                           hit_data,
    output logic [icache_pkg::NUM_WAYS-1:0]                         victim_sel
);

    import icache_pkg::*;

    logic [NUM_SETS-1:0][WAY_W-1:0] rr_ptr;
    logic [WAY_W-1:0]               victim_idx;
    logic [WAY_W-1:0]               fill_idx;
    logic                           found_inv;

    assign any_hit = |way_hit;

    // At most one way hits, so an OR mux is enough
    always_comb begin
        hit_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_data = hit_data | way_data[w];
            end
        end
    end

    always_comb begin
        victim_idx = rr_ptr[lookup_set];
        found_inv  = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found_inv && !way_valid[w][lookup_set]) begin
                victim_idx = WAY_W'(w); // First free way wins
                found_inv  = 1'b1;
            end
        end
    end

    assign victim_sel = NUM_WAYS'(1) << victim_idx;

    // One-hot to index
    always_comb begin
        fill_idx = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill_way_sel[w]) begin
                fill_idx = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr <= '0;
        end else if (fill_last) begin
            rr_ptr[fill_set] <= fill_idx + WAY_W'(1); // Wraps past the last way
        end
    end

    // Tags in one set must never match twice
    a_hit_onehot: assert property (
        @(posedge Clk) disable iff (!arst_n)
        $onehot0(way_hit)
    ) else $error("Multiple ways hit in set %0d", lookup_set);

endmodule

//--- hw/icache_way.sv
// One way; tag and data arrays have no reset, only valid bits are cleared
module icache_way (
    input  logic                             Clk,
    input  logic                             arst_n,
    // Lookup side
    input  logic [icache_pkg::SET_W-1:0]     lookup_set,
    input  logic [icache_pkg::TAG_W-1:0]     lookup_tag,
    input  logic [icache_pkg::WORD_W-1:0]    lookup_word,
    // Fill side
    input  logic                             fill_sel,
    input  logic [icache_pkg::SET_W-1:0]     fill_set,
    input  logic [icache_pkg::TAG_W-1:0]     fill_tag,
    input  logic [icache_pkg::WORD_W-1:0]    fill_word,
    input  logic [icache_pkg::DATA_W-1:0]    fill_data,
    input  logic                             fill_start,
    input  logic                             fill_beat,
    input  logic                             fill_last,
    input  logic                             inv_all,
    // Results
    output logic                             way_hit,
    output logic [icache_pkg::NUM_SETS-1:0]  way_valid,
    output logic [icache_pkg::DATA_W-1:0]    way_data
);

    import icache_pkg::*;

    localparam int DEPTH = NUM_SETS * BLOCK_WORDS;

    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    logic [DATA_W-1:0]   data_mem [DEPTH];
    logic [NUM_SETS-1:0] valid_q;

    logic [SET_W+WORD_W-1:0] rd_idx;
    logic [SET_W+WORD_W-1:0] wr_idx;

    assign rd_idx = {lookup_set, lookup_word};
    assign wr_idx = {fill_set, fill_word};

    // Combinational compare and read
    assign way_hit   = valid_q[lookup_set] && (tag_mem[lookup_set] == lookup_tag);
    assign way_data  = data_mem[rd_idx];
    assign way_valid = valid_q;

    // Valid bits
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (inv_all) begin
            valid_q <= '0;
        end else if (fill_sel && fill_start) begin
            valid_q[fill_set] <= 1'b0; // Line stays dead until last beat
        end else if (fill_sel && fill_last) begin
            valid_q[fill_set] <= 1'b1;
        end
    end

    // Beat-wise data writes
    always_ff @(posedge Clk) begin
        if (fill_sel && fill_beat) begin
            data_mem[wr_idx] <= fill_data;
        end
    end

    // Tag lands with the last beat
    always_ff @(posedge Clk) begin
        if (fill_sel && fill_last) begin
            tag_mem[fill_set] <= fill_tag;
        end
    end

    // Start and last come from different controller states
    a_start_last_excl: assert property (
        @(posedge Clk) disable iff (!arst_n)
        !(fill_start && fill_last)
    ) else $error("fill_start and fill_last together");

endmodule

//--- hw/icache_pkg.sv
// Geometry must be powers of two with at least two words per block; byte addressed fetch only
package icache_pkg;

    // Cache geometry
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;

    // Derived field widths
    localparam int BYTE_W   = $clog2(DATA_W / 8);
    localparam int WORD_W   = $clog2(BLOCK_WORDS);
    localparam int SET_W    = $clog2(NUM_SETS);
    localparam int WAY_W    = $clog2(NUM_WAYS);
    localparam int OFFSET_W = WORD_W + BYTE_W;
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;

    // Field positions, address is {tag, set, word, byte}
    localparam int WORD_LSB = BYTE_W;
    localparam int SET_LSB  = OFFSET_W;
    localparam int TAG_LSB  = OFFSET_W + SET_W;

    // Refill controller states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0, // Accepting lookups
        ST_REQ     = 2'd1, // Waiting on first beat
        ST_FILL    = 2'd2, // Beats arriving
        ST_RESPOND = 2'd3  // Block written, return the word
    } refill_state_e;

endpackage
